// ==== logic/board_io_macros.svh ====
`ifndef BOARD_IO_MACROS_SVH
`define BOARD_IO_MACROS_SVH

// Converter data widths
`define ADC_BITS 14
`define DAC_BITS 16

// Front panel LEDs
`define LED_COUNT 6

// Ethernet LED on top bit is active high, rest active low
`define LED_ACTIVE_LOW_MASK {1'b0, {(`LED_COUNT-1){1'b1}}}

// Watchdog kick counter, top bit drives WDI
`define WD_BITS 16

// Clock-ready samples kept for the DCM reset pulse
`define READY_HIST_DEPTH 6

// One active-low enable per SPI peripheral
`define SPI_SLAVES 8

`endif

// ==== logic/board_io_pkg.sv ====
package board_io_pkg;

`include "board_io_macros.svh"

   // Bit positions in the SPI enable vector
   typedef enum logic [2:0]
   {
      SLV_CLKGEN   = 3'd0,
      SLV_MAIN_DAC = 3'd1,
      SLV_TX_DB    = 3'd2,
      SLV_TX_ADC   = 3'd3,
      SLV_TX_DAC   = 3'd4,
      SLV_RX_DB    = 3'd5,
      SLV_RX_ADC   = 3'd6,
      SLV_RX_DAC   = 3'd7
   } spi_slave_e;

   typedef logic [`ADC_BITS-1:0] adc_sample_t;   // One ADC conversion
   typedef logic [`DAC_BITS-1:0] dac_word_t;     // One DAC code

   // LED vector as seen by the core and by the pins
   typedef logic [`LED_COUNT-1:0] led_vec_t;

endpackage

// ==== logic/converter_io.sv ====
`timescale 1ns/10ps

module converter_io import board_io_pkg::*;
(
   input  logic        dsp_clk,
   input  logic        rst_n_i,

   // ADC pins
   input  adc_sample_t adc_a_i,
   input  adc_sample_t adc_b_i,
   input  logic        adc_ovf_a_i,
   input  logic        adc_ovf_b_i,

   // Converter controls from the core
   input  logic        adc_on_a_i,
   input  logic        adc_on_b_i,
   input  logic        adc_oe_a_i,
   input  logic        adc_oe_b_i,

   // Retimed samples toward the core
   output adc_sample_t adc_a_o,
   output adc_sample_t adc_b_o,
   output logic        adc_ovf_a_o,
   output logic        adc_ovf_b_o,

   // Active-low control pins
   output logic        adc_oen_a_o,
   output logic        adc_oen_b_o,
   output logic        adc_pdn_a_o,
   output logic        adc_pdn_b_o,

   // DAC words and pins
   input  dac_word_t   dac_a_i,
   input  dac_word_t   dac_b_i,
   output dac_word_t   dac_a_o,
   output dac_word_t   dac_b_o
);

   adc_sample_t adc_a_s1;   // First capture stage at the pads
   adc_sample_t adc_b_s1;
   logic        ovf_a_s1;
   logic        ovf_b_s1;

   // Chip pins are active low, core side is active high
   assign adc_oen_a_o = ~adc_oe_a_i;
   assign adc_oen_b_o = ~adc_oe_b_i;
   assign adc_pdn_a_o = ~adc_on_a_i;
   assign adc_pdn_b_o = ~adc_on_b_i;

   // Two-stage sample capture, both channels in lockstep
   always_ff @(posedge dsp_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         adc_a_s1    <= '0;
         adc_b_s1    <= '0;
         ovf_a_s1    <= 1'b0;
         ovf_b_s1    <= 1'b0;
         adc_a_o     <= '0;
         adc_b_o     <= '0;
         adc_ovf_a_o <= 1'b0;
         adc_ovf_b_o <= 1'b0;
      end
      else
      begin
         adc_a_s1    <= adc_a_i;
         adc_b_s1    <= adc_b_i;
         ovf_a_s1    <= adc_ovf_a_i;
         ovf_b_s1    <= adc_ovf_b_i;
         adc_a_o     <= adc_a_s1;      // Second stage
         adc_b_o     <= adc_b_s1;
         adc_ovf_a_o <= ovf_a_s1;
         adc_ovf_b_o <= ovf_b_s1;
      end
   end

   // DAC latches on the rising edge, so launch half a cycle early
   always_ff @(negedge dsp_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         dac_a_o <= '0;
         dac_b_o <= '0;
      end
      else
      begin
         dac_a_o <= dac_a_i;
         dac_b_o <= dac_b_i;
      end
   end

endmodule

// ==== logic/spi_select_router.sv ====
`timescale 1ns/10ps

`include "board_io_macros.svh"

module spi_select_router import board_io_pkg::*;
(
   // Shared serial bus from the core
   input  logic                   sclk_i,
   input  logic                   mosi_i,
   input  logic [`SPI_SLAVES-1:0] sen_n_i,   // Indexed by spi_slave_e
   output logic                   miso_o,

   // Clock generator and main DAC share one pair
   output logic                   sclk_main_o,
   output logic                   sdi_main_o,

   // TX daughterboard side
   output logic                   sclk_tx_db_o,
   output logic                   sdi_tx_db_o,
   output logic                   sclk_tx_adc_o,
   output logic                   sdi_tx_adc_o,
   output logic                   sclk_tx_dac_o,
   output logic                   sdi_tx_dac_o,

   // RX daughterboard side
   output logic                   sclk_rx_db_o,
   output logic                   sdi_rx_db_o,
   output logic                   sclk_rx_adc_o,
   output logic                   sdi_rx_adc_o,
   output logic                   sclk_rx_dac_o,
   output logic                   sdi_rx_dac_o,

   // Returned data, board DACs are write only
   input  logic                   sdo_main_i,
   input  logic                   sdo_tx_db_i,
   input  logic                   sdo_tx_adc_i,
   input  logic                   sdo_rx_db_i,
   input  logic                   sdo_rx_adc_i
);

   logic [`SPI_SLAVES-1:0] sel;        // Active-high selects
   logic [1:0]             bus_pair;   // Clock and data together
   logic                   sel_main;

   assign sel      = ~sen_n_i;
   assign bus_pair = {sclk_i, mosi_i};
   assign sel_main = sel[SLV_CLKGEN] | sel[SLV_MAIN_DAC];

   // Unselected peripherals see a quiet bus
   assign {sclk_main_o, sdi_main_o}     = bus_pair & {2{sel_main}};
   assign {sclk_tx_db_o, sdi_tx_db_o}   = bus_pair & {2{sel[SLV_TX_DB]}};
   assign {sclk_tx_adc_o, sdi_tx_adc_o} = bus_pair & {2{sel[SLV_TX_ADC]}};
   assign {sclk_tx_dac_o, sdi_tx_dac_o} = bus_pair & {2{sel[SLV_TX_DAC]}};
   assign {sclk_rx_db_o, sdi_rx_db_o}   = bus_pair & {2{sel[SLV_RX_DB]}};
   assign {sclk_rx_adc_o, sdi_rx_adc_o} = bus_pair & {2{sel[SLV_RX_ADC]}};
   assign {sclk_rx_dac_o, sdi_rx_dac_o} = bus_pair & {2{sel[SLV_RX_DAC]}};

   // Wired-OR of whichever readable devices are selected
   assign miso_o = (sel_main          & sdo_main_i)
                 | (sel[SLV_TX_DB]    & sdo_tx_db_i)
                 | (sel[SLV_TX_ADC]   & sdo_tx_adc_i)
                 | (sel[SLV_RX_DB]    & sdo_rx_db_i)
                 | (sel[SLV_RX_ADC]   & sdo_rx_adc_i);

endmodule

// ==== logic/board_supervisor.sv ====
`timescale 1ns/10ps

`include "board_io_macros.svh"

module board_supervisor import board_io_pkg::*;
(
   input  logic     dsp_clk,
   input  logic     rst_n_i,

   // Watchdog
   input  logic     config_success_i,
   output logic     wdi_o,

   // Clock manager
   input  logic     clock_ready_i,
   output logic     pll_rst_o,

   // LEDs
   input  led_vec_t leds_i,
   output led_vec_t leds_o
);

   logic [`WD_BITS-1:0]          wd_cnt;
   logic [`READY_HIST_DEPTH-1:0] ready_hist;   // Newest sample in bit 0

   // Free-running kick counter, held at zero until config is done
   always_ff @(posedge dsp_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wd_cnt <= '0;
      end
      else if (!config_success_i)
      begin
         wd_cnt <= '0;
      end
      else
      begin
         wd_cnt <= wd_cnt + 1'b1;   // Wraps freely
      end
   end

   // Toggles every half counter period
   assign wdi_o = wd_cnt[`WD_BITS-1];

   // Clock-ready history
   always_ff @(posedge dsp_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         ready_hist <= '0;
      end
      else
      begin
         ready_hist <= {ready_hist[`READY_HIST_DEPTH-2:0], clock_ready_i};
      end
   end

   // Pulse while the history is mixed, i.e. just after
   // any edge of clock_ready until it has settled
   assign pll_rst_o = ~(&ready_hist) & (|ready_hist);

   // Polarity fix-up for the front panel
   assign leds_o = leds_i ^ `LED_ACTIVE_LOW_MASK;

endmodule

// ==== logic/board_io_top.sv ====
`timescale 1ns/10ps

`include "board_io_macros.svh"

module board_io_top import board_io_pkg::*;
(
   input  logic                   dsp_clk,
   input  logic                   rst_n_i,

   // ADC
   input  adc_sample_t            adc_a_i,
   input  adc_sample_t            adc_b_i,
   input  logic                   adc_ovf_a_i,
   input  logic                   adc_ovf_b_i,
   input  logic                   adc_on_a_i,
   input  logic                   adc_on_b_i,
   input  logic                   adc_oe_a_i,
   input  logic                   adc_oe_b_i,
   output adc_sample_t            adc_a_o,
   output adc_sample_t            adc_b_o,
   output logic                   adc_ovf_a_o,
   output logic                   adc_ovf_b_o,
   output logic                   adc_oen_a_o,
   output logic                   adc_oen_b_o,
   output logic                   adc_pdn_a_o,
   output logic                   adc_pdn_b_o,

   // DAC
   input  dac_word_t              dac_a_i,
   input  dac_word_t              dac_b_i,
   output dac_word_t              dac_a_o,
   output dac_word_t              dac_b_o,

   // SPI
   input  logic                   sclk_i,
   input  logic                   mosi_i,
   input  logic [`SPI_SLAVES-1:0] sen_n_i,
   output logic [`SPI_SLAVES-1:0] sen_n_o,   // Enables onward to the chips
   output logic                   miso_o,
   output logic                   sclk_main_o,
   output logic                   sdi_main_o,
   output logic                   sclk_tx_db_o,
   output logic                   sdi_tx_db_o,
   output logic                   sclk_tx_adc_o,
   output logic                   sdi_tx_adc_o,
   output logic                   sclk_tx_dac_o,
   output logic                   sdi_tx_dac_o,
   output logic                   sclk_rx_db_o,
   output logic                   sdi_rx_db_o,
   output logic                   sclk_rx_adc_o,
   output logic                   sdi_rx_adc_o,
   output logic                   sclk_rx_dac_o,
   output logic                   sdi_rx_dac_o,
   input  logic                   sdo_main_i,
   input  logic                   sdo_tx_db_i,
   input  logic                   sdo_tx_adc_i,
   input  logic                   sdo_rx_db_i,
   input  logic                   sdo_rx_adc_i,

   // Supervision
   input  logic                   config_success_i,
   input  logic                   clock_ready_i,
   output logic                   wdi_o,
   output logic                   pll_rst_o,
   input  led_vec_t               leds_i,
   output led_vec_t               leds_o
);

   assign sen_n_o = sen_n_i;   // Enables go to the chips unchanged

   converter_io conv0
   (
      .dsp_clk     (dsp_clk),      .rst_n_i     (rst_n_i),
      .adc_a_i     (adc_a_i),      .adc_b_i     (adc_b_i),
      .adc_ovf_a_i (adc_ovf_a_i),  .adc_ovf_b_i (adc_ovf_b_i),
      .adc_on_a_i  (adc_on_a_i),   .adc_on_b_i  (adc_on_b_i),
      .adc_oe_a_i  (adc_oe_a_i),   .adc_oe_b_i  (adc_oe_b_i),
      .adc_a_o     (adc_a_o),      .adc_b_o     (adc_b_o),
      .adc_ovf_a_o (adc_ovf_a_o),  .adc_ovf_b_o (adc_ovf_b_o),
      .adc_oen_a_o (adc_oen_a_o),  .adc_oen_b_o (adc_oen_b_o),
      .adc_pdn_a_o (adc_pdn_a_o),  .adc_pdn_b_o (adc_pdn_b_o),
      .dac_a_i     (dac_a_i),      .dac_b_i     (dac_b_i),
      .dac_a_o     (dac_a_o),      .dac_b_o     (dac_b_o)
   );

   spi_select_router spi0
   (
      .sclk_i        (sclk_i),         .mosi_i        (mosi_i),
      .sen_n_i       (sen_n_i),        .miso_o        (miso_o),
      .sclk_main_o   (sclk_main_o),    .sdi_main_o    (sdi_main_o),
      .sclk_tx_db_o  (sclk_tx_db_o),   .sdi_tx_db_o   (sdi_tx_db_o),
      .sclk_tx_adc_o (sclk_tx_adc_o),  .sdi_tx_adc_o  (sdi_tx_adc_o),
      .sclk_tx_dac_o (sclk_tx_dac_o),  .sdi_tx_dac_o  (sdi_tx_dac_o),
      .sclk_rx_db_o  (sclk_rx_db_o),   .sdi_rx_db_o   (sdi_rx_db_o),
      .sclk_rx_adc_o (sclk_rx_adc_o),  .sdi_rx_adc_o  (sdi_rx_adc_o),
      .sclk_rx_dac_o (sclk_rx_dac_o),  .sdi_rx_dac_o  (sdi_rx_dac_o),
      .sdo_main_i    (sdo_main_i),     .sdo_tx_db_i   (sdo_tx_db_i),
      .sdo_tx_adc_i  (sdo_tx_adc_i),   .sdo_rx_db_i   (sdo_rx_db_i),
      .sdo_rx_adc_i  (sdo_rx_adc_i)
   );

   board_supervisor sup0
   (
      .dsp_clk          (dsp_clk),
      .rst_n_i          (rst_n_i),
      .config_success_i (config_success_i),
      .wdi_o            (wdi_o),
      .clock_ready_i    (clock_ready_i),
      .pll_rst_o        (pll_rst_o),
      .leds_i           (leds_i),
      .leds_o           (leds_o)
   );

endmodule

// ==== verification/board_io_chk.sv ====
`timescale 1ns/10ps

`include "board_io_macros.svh"

module board_io_chk
(
   input logic dsp_clk,
   input logic rst_n_i,
   input logic config_success_i,
   input logic clock_ready_i,
   input logic wdi_i,
   input logic pll_rst_i
);

   logic       ready_q;      // clock_ready as sampled at the last edge
   logic [3:0] steady_cnt;   // Edges since clock_ready last changed

   always_ff @(posedge dsp_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         ready_q    <= 1'b0;
         steady_cnt <= '0;
      end
      else
      begin
         ready_q <= clock_ready_i;
         if (clock_ready_i != ready_q)
            steady_cnt <= '0;
         else if (steady_cnt != 4'hf)
            steady_cnt <= steady_cnt + 4'd1;   // Saturates
      end
   end

   // Kick is held off while configuration is pending
   wdi_idle_a : assert property (@(posedge dsp_clk) disable iff (!rst_n_i)
      !config_success_i |=> !wdi_i)
      else $error("wdi_o high one cycle after config_success_i was low");

   // Settled history ends the reset pulse
   pll_pulse_len_a : assert property (@(posedge dsp_clk) disable iff (!rst_n_i)
      (steady_cnt >= 4'(`READY_HIST_DEPTH - 1)) |-> !pll_rst_i)
      else $error("pll_rst_o still high after clock_ready_i settled");

   pll_rise_cause_a : assert property (@(posedge dsp_clk) disable iff (!rst_n_i)
      $rose(pll_rst_i) |-> (steady_cnt == 4'd0))
      else $error("pll_rst_o rose without a change of clock_ready_i");

endmodule

bind board_supervisor board_io_chk chk0
(
   .dsp_clk          (dsp_clk),
   .rst_n_i          (rst_n_i),
   .config_success_i (config_success_i),
   .clock_ready_i    (clock_ready_i),
   .wdi_i            (wdi_o),
   .pll_rst_i        (pll_rst_o)
);

// ==== verification/board_io_tb.sv ====
`timescale 1ns/10ps

`include "board_io_macros.svh"

module board_io_tb import board_io_pkg::*; ();

   localparam int CLK_PERIOD   = 100;
   localparam int SETTLE       = 25;   // Sample point after the falling edge
   localparam int ROUNDS       = 500;
   localparam int READY_ROUNDS = 400;
   localparam int WD_IDLE      = 100;
   localparam int WD_RUN       = 70000;
   localparam int WD_HALF      = 1 << (`WD_BITS - 1);   // Cycles between WDI toggles
   localparam int WD_DROP      = 4;
   localparam int MAX_CYCLES   = 3 * ROUNDS + READY_ROUNDS + WD_IDLE + WD_RUN
                               + WD_HALF + WD_DROP + 1000;
   localparam int PIPE_W       = 2 * `ADC_BITS + 2;

   logic                   dsp_clk;
   logic                   rst_n_i;
   adc_sample_t            adc_a_i, adc_b_i, adc_a_o, adc_b_o;
   logic                   adc_ovf_a_i, adc_ovf_b_i, adc_ovf_a_o, adc_ovf_b_o;
   logic                   adc_on_a_i, adc_on_b_i, adc_oe_a_i, adc_oe_b_i;
   logic                   adc_oen_a_o, adc_oen_b_o, adc_pdn_a_o, adc_pdn_b_o;
   dac_word_t              dac_a_i, dac_b_i, dac_a_o, dac_b_o;
   logic                   sclk_i, mosi_i, miso_o;
   logic [`SPI_SLAVES-1:0] sen_n_i, sen_n_o;
   logic                   sclk_main_o, sdi_main_o, sclk_tx_db_o, sdi_tx_db_o;
   logic                   sclk_tx_adc_o, sdi_tx_adc_o, sclk_tx_dac_o, sdi_tx_dac_o;
   logic                   sclk_rx_db_o, sdi_rx_db_o, sclk_rx_adc_o, sdi_rx_adc_o;
   logic                   sclk_rx_dac_o, sdi_rx_dac_o;
   logic                   sdo_main_i, sdo_tx_db_i, sdo_tx_adc_i, sdo_rx_db_i, sdo_rx_adc_i;
   logic                   config_success_i, clock_ready_i, wdi_o, pll_rst_o;
   led_vec_t               leds_i, leds_o;

   int errors      = 0;
   int checks      = 0;
   int test_errors = 0;
   int test_checks = 0;
   int tests_run   = 0;

   board_io_top dut0 (.*);

   always #(CLK_PERIOD / 2) dsp_clk = ~dsp_clk;

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      test_checks++;
      if (got !== exp)
      begin
         errors++;
         test_errors++;
         $display("CHECK FAILED: %s = 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
      end
   endtask

   task automatic report_test(input string name);
      tests_run++;
      $display("test %0d %s: %0d checks, %0d mismatches", tests_run, name, test_checks,
               test_errors);
      test_checks = 0;
      test_errors = 0;
   endtask

   // Idle peripheral sees 0 on both lines
   task automatic check_pair(input string name, input logic [1:0] got, input logic en,
                             input logic [1:0] bus);
      compare($sformatf("{sclk_%s_o,sdi_%s_o}", name, name), 32'(got),
              32'(en ? bus : 2'b00));
   endtask

   task automatic check_adc_capture();
      logic [PIPE_W-1:0] pipe[$];
      logic [PIPE_W-1:0] now_in;
      logic [PIPE_W-1:0] old;
      logic [3:0]        ctl;
      logic [1:0]        pdn_exp;
      logic [1:0]        oen_exp;
      int                i;
      now_in = {adc_ovf_a_i, adc_ovf_b_i, adc_a_i, adc_b_i};
      pipe.push_back(now_in);   // Both stages hold the idle input
      pipe.push_back(now_in);
      for (i = 0; i < ROUNDS; i++)
      begin
         @(negedge dsp_clk);
         now_in = PIPE_W'($urandom);
         ctl    = 4'($urandom);
         {adc_ovf_a_i, adc_ovf_b_i, adc_a_i, adc_b_i} <= now_in;
         {adc_on_a_i, adc_on_b_i, adc_oe_a_i, adc_oe_b_i} <= ctl;
         pipe.push_back(now_in);
         old     = pipe.pop_front();   // Driven two rising edges ago
         pdn_exp = ~ctl[3:2];
         oen_exp = ~ctl[1:0];
         #SETTLE;
         compare("adc_a_o", 32'(adc_a_o), 32'(old[2*`ADC_BITS-1:`ADC_BITS]));
         compare("adc_b_o", 32'(adc_b_o), 32'(old[`ADC_BITS-1:0]));
         compare("{adc_ovf_a_o,adc_ovf_b_o}", 32'({adc_ovf_a_o, adc_ovf_b_o}),
                 32'(old[PIPE_W-1:PIPE_W-2]));
         compare("{adc_pdn_a_o,adc_pdn_b_o}", 32'({adc_pdn_a_o, adc_pdn_b_o}), 32'(pdn_exp));
         compare("{adc_oen_a_o,adc_oen_b_o}", 32'({adc_oen_a_o, adc_oen_b_o}), 32'(oen_exp));
      end
   endtask

   task automatic check_dac_launch();
      dac_word_t prev_a;
      dac_word_t prev_b;
      dac_word_t next_a;
      dac_word_t next_b;
      int        i;
      prev_a = dac_a_i;
      prev_b = dac_b_i;
      for (i = 0; i < ROUNDS; i++)
      begin
         @(negedge dsp_clk);
         next_a = dac_word_t'($urandom);
         next_b = dac_word_t'($urandom);
         dac_a_i <= next_a;
         dac_b_i <= next_b;
         #SETTLE;
         compare("dac_a_o", 32'(dac_a_o), 32'(prev_a));
         compare("dac_b_o", 32'(dac_b_o), 32'(prev_b));
         prev_a = next_a;
         prev_b = next_b;
      end
   endtask

   task automatic check_spi_routing();
      logic [`SPI_SLAVES-1:0] sen;
      logic [`SPI_SLAVES-1:0] sel;
      logic [4:0]             sdo;
      logic [1:0]             bus;   // {sclk, mosi}
      logic                   main;
      logic                   miso;
      int                     i;
      for (i = 0; i < ROUNDS; i++)
      begin
         @(negedge dsp_clk);
         sen = `SPI_SLAVES'($urandom);
         sdo = 5'($urandom);
         bus = 2'($urandom);
         sen_n_i <= sen;
         {sclk_i, mosi_i} <= bus;
         {sdo_main_i, sdo_tx_db_i, sdo_tx_adc_i, sdo_rx_db_i, sdo_rx_adc_i} <= sdo;
         sel  = ~sen;
         main = sel[SLV_CLKGEN] | sel[SLV_MAIN_DAC];   // Shared pin pair
         miso = (main & sdo[4]) | (sel[SLV_TX_DB] & sdo[3]) | (sel[SLV_TX_ADC] & sdo[2])
              | (sel[SLV_RX_DB] & sdo[1]) | (sel[SLV_RX_ADC] & sdo[0]);
         #SETTLE;
         compare("sen_n_o", 32'(sen_n_o), 32'(sen));
         compare("miso_o", 32'(miso_o), 32'(miso));
         check_pair("main", {sclk_main_o, sdi_main_o}, main, bus);
         check_pair("tx_db", {sclk_tx_db_o, sdi_tx_db_o}, sel[SLV_TX_DB], bus);
         check_pair("tx_adc", {sclk_tx_adc_o, sdi_tx_adc_o}, sel[SLV_TX_ADC], bus);
         check_pair("tx_dac", {sclk_tx_dac_o, sdi_tx_dac_o}, sel[SLV_TX_DAC], bus);
         check_pair("rx_db", {sclk_rx_db_o, sdi_rx_db_o}, sel[SLV_RX_DB], bus);
         check_pair("rx_adc", {sclk_rx_adc_o, sdi_rx_adc_o}, sel[SLV_RX_ADC], bus);
         check_pair("rx_dac", {sclk_rx_dac_o, sdi_rx_dac_o}, sel[SLV_RX_DAC], bus);
      end
   endtask

   task automatic check_pll_reset();
      logic [`READY_HIST_DEPTH-1:0] hist;
      logic                         ready;
      int                           hold;
      int                           i;
      @(negedge dsp_clk);
      clock_ready_i <= 1'b1;   // One new sample leaves the history mixed
      @(negedge dsp_clk);
      compare("pll_rst_o", 32'(pll_rst_o), 32'd1);
      rst_n_i       <= 1'b0;
      clock_ready_i <= 1'b0;
      repeat (2) @(posedge dsp_clk);
      #SETTLE;
      compare("pll_rst_o", 32'(pll_rst_o), 32'd0);
      compare("adc_a_o", 32'(adc_a_o), 32'd0);
      compare("dac_a_o", 32'(dac_a_o), 32'd0);
      @(negedge dsp_clk);
      rst_n_i <= 1'b1;
      hist  = '0;
      ready = 1'b0;
      hold  = 8;
      for (i = 0; i < READY_ROUNDS; i++)
      begin
         @(negedge dsp_clk);
         hist = {hist[`READY_HIST_DEPTH-2:0], clock_ready_i};   // Taken at the last rise
         if (hold == 0)
         begin
            ready = ~ready;
            hold  = $urandom_range(1, 10);
         end
         hold--;
         clock_ready_i <= ready;
         #SETTLE;
         compare("pll_rst_o", 32'(pll_rst_o), 32'((hist != '0) && (hist != '1)));
      end
   endtask

   // One cycle of fresh LED data and the kick counter model
   task automatic step_watchdog(input logic cfg, inout logic [`WD_BITS-1:0] cnt);
      led_vec_t leds;
      led_vec_t mask;
      mask = ~(led_vec_t'(1) << (`LED_COUNT - 1));   // Ethernet LED keeps polarity
      @(negedge dsp_clk);
      cnt  = config_success_i ? cnt + `WD_BITS'(1) : '0;
      leds = led_vec_t'($urandom);
      leds_i           <= leds;
      config_success_i <= cfg;
      #SETTLE;
      compare("wdi_o", 32'(wdi_o), 32'(cnt[`WD_BITS-1]));
      compare("leds_o", 32'(leds_o), 32'(leds ^ mask));
   endtask

   task automatic check_watchdog_leds();
      logic [`WD_BITS-1:0] cnt;
      logic                wdi_prev;
      int                  toggles;
      int                  i;
      cnt      = '0;
      wdi_prev = 1'b0;
      toggles  = 0;
      for (i = 0; i < WD_IDLE + WD_RUN; i++)
      begin
         step_watchdog(i >= WD_IDLE, cnt);
         if (wdi_o !== wdi_prev)
            toggles++;
         wdi_prev = wdi_o;
      end
      compare("wdi_o toggles", 32'(toggles), 32'(WD_RUN / WD_HALF));
      // Count on until WDI is high, then withdraw config
      i = 0;
      while (!cnt[`WD_BITS-1] && i < WD_HALF)
      begin
         step_watchdog(1'b1, cnt);
         i++;
      end
      repeat (WD_DROP)
         step_watchdog(1'b0, cnt);
   endtask

   initial
   begin
      void'($urandom(32'hfc5f18fc));
      dsp_clk = 1'b0;
      rst_n_i = 1'b0;
      {adc_a_i, adc_b_i, adc_ovf_a_i, adc_ovf_b_i} = '0;
      {adc_on_a_i, adc_on_b_i, adc_oe_a_i, adc_oe_b_i} = '0;
      dac_a_i = '0;
      dac_b_i = '0;
      {sclk_i, mosi_i} = 2'b00;
      sen_n_i = '1;   // Every peripheral deselected
      {sdo_main_i, sdo_tx_db_i, sdo_tx_adc_i, sdo_rx_db_i, sdo_rx_adc_i} = '0;
      config_success_i = 1'b0;
      clock_ready_i    = 1'b0;
      leds_i           = '0;
      repeat (2) @(posedge dsp_clk);
      @(negedge dsp_clk);
      rst_n_i <= 1'b1;
      check_adc_capture();
      report_test("adc capture");
      check_dac_launch();
      report_test("dac launch");
      check_spi_routing();
      report_test("spi routing");
      check_pll_reset();
      report_test("clock manager reset");
      check_watchdog_leds();
      report_test("watchdog and leds");
      $display("Summary: %0d tests, %0d checks, %0d mismatches", tests_run, checks, errors);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

   // Run limit from the summed test lengths
   initial
   begin
      #(MAX_CYCLES * CLK_PERIOD);
      $display("Timeout: tests still running after %0d clock cycles", MAX_CYCLES);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

// ==== board_io_top.f ====
+incdir+logic
logic/board_io_pkg.sv
logic/converter_io.sv
logic/spi_select_router.sv
logic/board_supervisor.sv
logic/board_io_top.sv
verification/board_io_chk.sv
verification/board_io_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the board I/O testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module board_io_tb \
   -f board_io_top.f -Mdir obj_dir -o board_io_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/board_io_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
   exit 0
fi
exit 1
